// ==== debug_defines.svh ====
`ifndef DEBUG_DEFINES_SVH
`define DEBUG_DEFINES_SVH

`default_nettype none

// host command bytes
`define DBG_CMD_LOAD      8'd1
`define DBG_CMD_RUN       8'd4
`define DBG_CMD_STEP      8'd5
`define DBG_CMD_SEND_BR   8'd6
`define DBG_CMD_SEND_PC   8'd7
`define DBG_CMD_SEND_MEM  8'd8

// data memory as seen by a dump
`define DBG_DM_DEPTH      64
`define DBG_DM_ADDR_W     6

// register bank
`define DBG_BR_COUNT      32
`define DBG_BR_ADDR_W     5

// instruction memory byte address
`define DBG_IM_ADDR_W     16

// outgoing byte queue
`define DBG_FIFO_DEPTH    8
`define DBG_FIFO_ADDR_W   3

`default_nettype wire

`endif

// ==== debug_pkg.sv ====
`include "debug_defines.svh"
`default_nettype none

package debug_pkg;

    // debug unit FSM
    typedef enum logic [2:0] {
        st_idle,     // waiting for a command byte
        st_size,     // two size bytes of a load
        st_data,     // program bytes of a load
        st_run,      // cpu free running until halt
        st_send_br,  // register bank dump
        st_send_pc,  // program counter dump
        st_send_mem  // data memory dump
    } dbg_state_t;

    // instruction memory write port
    typedef struct packed {
        logic [`DBG_IM_ADDR_W-1:0] addr; // byte address
        logic [7:0]                data;
    } im_write_t;

    // one queued output byte
    typedef struct packed {
        logic [7:0] data;
        logic       last; // final byte of a dump
    } tx_byte_t;

    // byte handed over by the uart receiver
    typedef struct packed {
        logic       done; // one cycle strobe
        logic [7:0] data;
    } uart_rx_t;

endpackage

`default_nettype wire

// ==== debug_unit.sv ====
`timescale 1ns/1ps
`include "debug_defines.svh"
`default_nettype none

module debug_unit (
    input  wire logic                        i_clock,
    input  wire logic                        i_reset,
    input  wire debug_pkg::uart_rx_t         i_rx,
    input  wire logic                        i_hlt,
    input  wire logic [31:0]                 i_pc_value,
    input  wire logic [31:0]                 i_br_data,
    input  wire logic [7:0]                  i_dm_data,
    input  wire logic                        i_fifo_full,
    output debug_pkg::im_write_t             o_im_wr,
    output logic                             o_im_write_enable,
    output logic                             o_cpu_enable,
    output logic [`DBG_BR_ADDR_W-1:0]        o_br_addr,
    output logic [`DBG_DM_ADDR_W-1:0]        o_dm_addr,
    output logic                             o_push,
    output debug_pkg::tx_byte_t              o_push_byte
);
    import debug_pkg::*;

    // last register and last memory byte of a dump
    localparam logic [`DBG_BR_ADDR_W-1:0] br_last = `DBG_BR_ADDR_W'(`DBG_BR_COUNT - 1);
    localparam logic [`DBG_DM_ADDR_W-1:0] dm_last = `DBG_DM_ADDR_W'(`DBG_DM_DEPTH - 1);

    dbg_state_t                 state;
    logic                       size_hi;  // next size byte is the upper one
    logic [`DBG_IM_ADDR_W-1:0]  size_q;   // program length in bytes
    logic [`DBG_IM_ADDR_W-1:0]  im_addr;  // next write address
    logic [1:0]                 byte_sel; // byte of the current 32 bit word
    logic [`DBG_BR_ADDR_W-1:0]  br_addr;
    logic [`DBG_DM_ADDR_W-1:0]  dm_addr;

    // lsb first slicing of a word
    function automatic logic [7:0] word_byte(input logic [31:0] word, input logic [1:0] sel);
        return word[{sel, 3'b000} +: 8];
    endfunction

    assign o_br_addr = br_addr; // datapath answers in the same cycle
    assign o_dm_addr = dm_addr;

    // byte offered to the fifo while dumping
    always_comb begin
        o_push      = 1'b0;
        o_push_byte = '{data: 8'h00, last: 1'b0};
        case (state)
            st_send_br: begin
                o_push           = !i_fifo_full;
                o_push_byte.data = word_byte(i_br_data, byte_sel);
                o_push_byte.last = (br_addr == br_last) && (byte_sel == 2'd3);
            end
            st_send_pc: begin
                o_push           = !i_fifo_full;
                o_push_byte.data = word_byte(i_pc_value, byte_sel);
                o_push_byte.last = (byte_sel == 2'd3);
            end
            st_send_mem: begin
                o_push           = !i_fifo_full;
                o_push_byte.data = i_dm_data;
                o_push_byte.last = (dm_addr == dm_last);
            end
            default: ; // nothing to send
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state             <= st_idle;
            size_hi           <= 1'b0;
            size_q            <= '0;
            im_addr           <= '0;
            byte_sel          <= '0;
            br_addr           <= '0;
            dm_addr           <= '0;
            o_im_write_enable <= 1'b0;
            o_cpu_enable      <= 1'b0;
        end else begin
            o_im_write_enable <= 1'b0; // strobes default low
            o_cpu_enable      <= 1'b0;
            case (state)
                st_idle: begin
                    // counters start from zero for every command
                    size_hi  <= 1'b0;
                    im_addr  <= '0;
                    byte_sel <= '0;
                    br_addr  <= '0;
                    dm_addr  <= '0;
                    if (i_rx.done) begin
                        case (i_rx.data)
                            `DBG_CMD_LOAD:     state <= st_size;
                            `DBG_CMD_RUN: begin
                                state        <= st_run;
                                o_cpu_enable <= 1'b1;
                            end
                            `DBG_CMD_STEP:     o_cpu_enable <= 1'b1; // single cycle
                            `DBG_CMD_SEND_BR:  state <= st_send_br;
                            `DBG_CMD_SEND_PC:  state <= st_send_pc;
                            `DBG_CMD_SEND_MEM: state <= st_send_mem;
                            default: ;         // unknown byte dropped
                        endcase
                    end
                end
                st_size: begin
                    if (i_rx.done) begin
                        if (!size_hi) begin
                            size_q[7:0] <= i_rx.data; // low byte first
                            size_hi     <= 1'b1;
                        end else begin
                            size_q[15:8] <= i_rx.data;
                            // empty program goes straight back
                            if ({i_rx.data, size_q[7:0]} == '0)
                                state <= st_idle;
                            else
                                state <= st_data;
                        end
                    end
                end
                st_data: begin
                    if (i_rx.done) begin
                        o_im_write_enable <= 1'b1;
                        im_addr           <= im_addr + 1'b1;
                        if (im_addr == size_q - 1'b1)
                            state <= st_idle; // last program byte
                    end
                end
                st_run: begin
                    if (i_hlt)
                        state <= st_idle;
                    else
                        o_cpu_enable <= 1'b1;
                end
                st_send_br: begin
                    if (o_push) begin
                        byte_sel <= byte_sel + 1'b1;
                        if (byte_sel == 2'd3) begin
                            br_addr <= br_addr + 1'b1; // next register
                            if (br_addr == br_last)
                                state <= st_idle;
                        end
                    end
                end
                st_send_pc: begin
                    if (o_push) begin
                        byte_sel <= byte_sel + 1'b1;
                        if (byte_sel == 2'd3)
                            state <= st_idle;
                    end
                end
                st_send_mem: begin
                    if (o_push) begin
                        dm_addr <= dm_addr + 1'b1;
                        if (dm_addr == dm_last)
                            state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // write port payload follows the received byte
    always_ff @(posedge i_clock) begin
        if (state == st_data && i_rx.done)
            o_im_wr <= '{addr: im_addr, data: i_rx.data};
    end

endmodule

`default_nettype wire

// ==== tx_fifo.sv ====
`timescale 1ns/1ps
`include "debug_defines.svh"
`default_nettype none

module tx_fifo (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire logic                 i_push,
    input  wire debug_pkg::tx_byte_t  i_push_byte,
    input  wire logic                 i_pop,
    output debug_pkg::tx_byte_t       o_head,
    output logic                      o_empty,
    output logic                      o_full
);
    import debug_pkg::*;

    localparam logic [`DBG_FIFO_ADDR_W:0] full_count =
        (`DBG_FIFO_ADDR_W + 1)'(`DBG_FIFO_DEPTH);

    tx_byte_t                    mem [`DBG_FIFO_DEPTH];
    logic [`DBG_FIFO_ADDR_W-1:0] wr_ptr;
    logic [`DBG_FIFO_ADDR_W-1:0] rd_ptr;
    logic [`DBG_FIFO_ADDR_W:0]   count;   // entries held
    logic                        do_push;
    logic                        do_pop;

    assign do_push = i_push && !o_full;  // guarded
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // both or neither keeps count
            endcase
        end
    end

    // storage
    always_ff @(posedge i_clock) begin
        if (do_push)
            mem[wr_ptr] <= i_push_byte;
    end

    assign o_head  = mem[rd_ptr]; // peek without pop
    assign o_empty = (count == '0);
    assign o_full  = (count == full_count);

endmodule

`default_nettype wire

// ==== tx_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_sender (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire debug_pkg::tx_byte_t  i_head,
    input  wire logic                 i_empty,
    input  wire logic                 i_tx_done,
    output logic                      o_pop,
    output logic [7:0]                o_tx_data,
    output logic                      o_tx_start,
    output logic                      o_dump_done
);
    import debug_pkg::*;

    typedef enum logic {
        s_idle,
        s_busy  // transmitter owns the byte
    } sender_state_t;

    sender_state_t state;
    tx_byte_t      cur;   // byte on the line

    assign o_pop = (state == s_idle) && !i_empty;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= s_idle;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                s_idle: begin
                    if (o_pop) begin
                        state      <= s_busy;
                        o_tx_start <= 1'b1; // one cycle start
                    end
                end
                s_busy: begin
                    if (i_tx_done)
                        state <= s_idle; // free for next pop
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (o_pop)
            cur <= i_head;
    end

    assign o_tx_data   = cur.data;
    // end of a dump seen on the line
    assign o_dump_done = (state == s_busy) && i_tx_done && cur.last;

endmodule

`default_nettype wire

// ==== debug_top.sv ====
`timescale 1ns/1ps
`include "debug_defines.svh"
`default_nettype none

module debug_top (
    input  wire logic                        i_clock,
    input  wire logic                        i_reset,
    input  wire debug_pkg::uart_rx_t         i_rx,
    input  wire logic                        i_hlt,
    input  wire logic [31:0]                 i_pc_value,
    input  wire logic [31:0]                 i_br_data,
    input  wire logic [7:0]                  i_dm_data,
    input  wire logic                        i_tx_done,
    output debug_pkg::im_write_t             o_im_wr,
    output logic                             o_im_write_enable,
    output logic                             o_cpu_enable,
    output logic [`DBG_BR_ADDR_W-1:0]        o_br_addr,
    output logic [`DBG_DM_ADDR_W-1:0]        o_dm_addr,
    output logic [7:0]                       o_tx_data,
    output logic                             o_tx_start,
    output logic                             o_dump_done
);
    import debug_pkg::*;

    logic     push;      // producer to fifo
    tx_byte_t push_byte;
    logic     fifo_full;
    tx_byte_t head;      // fifo to sender
    logic     fifo_empty;
    logic     pop;

    // command decoder and dump producer
    debug_unit debug_unit_inst (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx              (i_rx),
        .i_hlt             (i_hlt),
        .i_pc_value        (i_pc_value),
        .i_br_data         (i_br_data),
        .i_dm_data         (i_dm_data),
        .i_fifo_full       (fifo_full),
        .o_im_wr           (o_im_wr),
        .o_im_write_enable (o_im_write_enable),
        .o_cpu_enable      (o_cpu_enable),
        .o_br_addr         (o_br_addr),
        .o_dm_addr         (o_dm_addr),
        .o_push            (push),
        .o_push_byte       (push_byte)
    );

    tx_fifo tx_fifo_inst (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_push      (push),
        .i_push_byte (push_byte),
        .i_pop       (pop),
        .o_head      (head),
        .o_empty     (fifo_empty),
        .o_full      (fifo_full)
    );

    // uart transmitter side
    tx_sender tx_sender_inst (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_head      (head),
        .i_empty     (fifo_empty),
        .i_tx_done   (i_tx_done),
        .o_pop       (pop),
        .o_tx_data   (o_tx_data),
        .o_tx_start  (o_tx_start),
        .o_dump_done (o_dump_done)
    );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`include "debug_defines.svh"
`default_nettype none

module tb_checker (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire debug_pkg::uart_rx_t  i_rx,
    input  wire logic                 i_hlt,
    input  wire debug_pkg::im_write_t i_im_wr,
    input  wire logic                 i_im_write_enable,
    input  wire logic                 i_cpu_enable,
    input  wire logic [7:0]           i_tx_data,
    input  wire logic                 i_tx_start,
    input  wire logic                 i_dump_done,
    input  wire logic                 i_note,      // stimulus announces what comes next
    input  wire logic [7:0]           i_note_cmd,
    input  wire debug_pkg::im_write_t i_note_wr,
    input  wire logic [31:0]          i_br_model [`DBG_BR_COUNT],
    input  wire logic [7:0]           i_dm_model [`DBG_DM_DEPTH],
    input  wire logic [31:0]          i_pc_model,
    output int                        o_errors,
    output int                        o_checks,
    output int                        o_dumps_seen
);
    import debug_pkg::*;

    tx_byte_t   exp_tx [$];   // bytes the transmitter must see
    im_write_t  exp_wr [$];   // program writes still due
    tx_byte_t   want_tx;
    im_write_t  want_wr;
    logic [7:0] cpu_arm;      // run or step announced and waiting for its strobe
    logic       exp_cpu;      // o_cpu_enable at the next sample
    logic       running;
    logic       rx_done_d;    // receive strobe one sample back
    int         last_due;     // final bytes sent without their dump_done yet
    int         dumps_noted;

    // byte idx of a dump stream from the datapath models
    function automatic logic [7:0] dump_byte(input logic [7:0] cmd, input int idx);
        logic [31:0] word;
        case (cmd)
            `DBG_CMD_SEND_BR: word = i_br_model[5'(idx / 4)];
            `DBG_CMD_SEND_PC: word = i_pc_model;
            default:          return i_dm_model[6'(idx)]; // one byte per address
        endcase
        return 8'(word >> (8 * (idx % 4))); // lsb first
    endfunction

    function automatic int dump_length(input logic [7:0] cmd);
        case (cmd)
            `DBG_CMD_SEND_BR: return 4 * `DBG_BR_COUNT;
            `DBG_CMD_SEND_PC: return 4;
            default:          return `DBG_DM_DEPTH;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        o_errors++;
        $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, want, got);
    endtask

    task automatic report_problem(input string what);
        o_errors++;
        $display("at %0t ns: %s", $time, what);
    endtask

    task automatic queue_expectation();
        tx_byte_t t;
        int       n;
        if (i_note_cmd == `DBG_CMD_LOAD) begin
            exp_wr.push_back(i_note_wr); // one program byte
        end else if (i_note_cmd == `DBG_CMD_RUN || i_note_cmd == `DBG_CMD_STEP) begin
            cpu_arm = i_note_cmd;
        end else begin
            n = dump_length(i_note_cmd);
            for (int i = 0; i < n; i++) begin
                t.data = dump_byte(i_note_cmd, i);
                t.last = (i == n - 1);
                exp_tx.push_back(t);
            end
            dumps_noted++;
        end
    endtask

    // leftovers at the end as a number of problems
    function automatic int end_checks();
        int bad;
        bad = 0;
        if (exp_tx.size() != 0) begin
            $display("%0d expected bytes never reached the transmitter", exp_tx.size());
            bad++;
        end
        if (exp_wr.size() != 0) begin
            $display("%0d program writes never happened", exp_wr.size());
            bad++;
        end
        if (o_dumps_seen != dumps_noted) begin
            $display("saw %0d dump_done pulses for %0d dumps", o_dumps_seen, dumps_noted);
            bad++;
        end
        return bad;
    endfunction

    // pre-edge values settled since the falling edge
    always @(posedge i_clock) begin
        if (i_reset) begin
            exp_tx.delete();
            exp_wr.delete();
            cpu_arm      = 8'h00;
            exp_cpu      = 1'b0;
            running      = 1'b0;
            rx_done_d    = 1'b0;
            last_due     = 0;
            dumps_noted  = 0;
            o_errors     = 0;
            o_checks     = 0;
            o_dumps_seen = 0;
        end else begin
            if (i_note)
                queue_expectation();
            // run and step enable
            o_checks++;
            if (i_cpu_enable !== exp_cpu)
                report_mismatch("o_cpu_enable", 32'(exp_cpu), 32'(i_cpu_enable));
            if (cpu_arm != 8'h00 && i_rx.done) begin
                exp_cpu = 1'b1;             // high one cycle after the command
                running = (cpu_arm == `DBG_CMD_RUN);
                cpu_arm = 8'h00;
            end else if (running && !i_hlt) begin
                exp_cpu = 1'b1;
            end else begin
                exp_cpu = 1'b0;             // low from the cycle after halt
                running = 1'b0;
            end
            // program writes
            if (i_im_write_enable) begin
                o_checks++;
                if (!rx_done_d)
                    report_problem("instruction write not one cycle after a received byte");
                if (exp_wr.size() == 0) begin
                    report_problem("unexpected instruction write");
                end else begin
                    want_wr = exp_wr.pop_front();
                    if (i_im_wr.addr !== want_wr.addr)
                        report_mismatch("o_im_wr.addr", 32'(want_wr.addr), 32'(i_im_wr.addr));
                    if (i_im_wr.data !== want_wr.data)
                        report_mismatch("o_im_wr.data", 32'(want_wr.data), 32'(i_im_wr.data));
                end
            end
            rx_done_d = i_rx.done;
            // dump bytes
            if (i_tx_start) begin
                o_checks++;
                if (exp_tx.size() == 0) begin
                    report_problem("unexpected byte started on the transmitter");
                end else begin
                    want_tx = exp_tx.pop_front();
                    if (i_tx_data !== want_tx.data)
                        report_mismatch("o_tx_data", 32'(want_tx.data), 32'(i_tx_data));
                    if (want_tx.last)
                        last_due++;
                end
            end
            if (i_dump_done) begin
                o_checks++;
                o_dumps_seen++;
                if (last_due == 0)
                    report_problem("o_dump_done without a final byte on the line");
                else
                    last_due--;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_debug_top.sv ====
`timescale 1ns/1ps
`include "debug_defines.svh"
`default_nettype none

module tb_debug_top;
    import debug_pkg::*;

    // all dump bytes plus every received byte at 20 cycles each
    localparam int expected_bytes = 4 * `DBG_BR_COUNT + `DBG_DM_DEPTH + 4 + 38;
    localparam int cycle_limit    = 20 * expected_bytes + 400;

    logic                      clock;
    logic                      reset;
    uart_rx_t                  rx;
    logic                      hlt;
    logic                      tx_done;
    im_write_t                 im_wr;
    logic                      im_write_enable;
    logic                      cpu_enable;
    logic [`DBG_BR_ADDR_W-1:0] br_addr;
    logic [`DBG_DM_ADDR_W-1:0] dm_addr;
    logic [7:0]                tx_data;
    logic                      tx_start;
    logic                      dump_done;
    logic [31:0]               br_model [`DBG_BR_COUNT]; // datapath state
    logic [7:0]                dm_model [`DBG_DM_DEPTH];
    logic [31:0]               pc_model;
    logic                      note;
    logic [7:0]                note_cmd;
    im_write_t                 note_wr;
    int                        errors;
    int                        checks;
    int                        dumps_seen;
    int                        seed = 32'hc23a;
    int                        tx_seed = 32'hc23a + 1; // own stream for the tx model
    int                        cycles = 0;
    int                        total_errors;

    debug_top debug_top_inst (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_rx              (rx),
        .i_hlt             (hlt),
        .i_pc_value        (pc_model),
        .i_br_data         (br_model[br_addr]), // combinational reads
        .i_dm_data         (dm_model[dm_addr]),
        .i_tx_done         (tx_done),
        .o_im_wr           (im_wr),
        .o_im_write_enable (im_write_enable),
        .o_cpu_enable      (cpu_enable),
        .o_br_addr         (br_addr),
        .o_dm_addr         (dm_addr),
        .o_tx_data         (tx_data),
        .o_tx_start        (tx_start),
        .o_dump_done       (dump_done)
    );

    tb_checker tb_checker_inst (
        .i_clock           (clock),
        .i_reset           (reset),
        .i_rx              (rx),
        .i_hlt             (hlt),
        .i_im_wr           (im_wr),
        .i_im_write_enable (im_write_enable),
        .i_cpu_enable      (cpu_enable),
        .i_tx_data         (tx_data),
        .i_tx_start        (tx_start),
        .i_dump_done       (dump_done),
        .i_note            (note),
        .i_note_cmd        (note_cmd),
        .i_note_wr         (note_wr),
        .i_br_model        (br_model),
        .i_dm_model        (dm_model),
        .i_pc_model        (pc_model),
        .o_errors          (errors),
        .o_checks          (checks),
        .o_dumps_seen      (dumps_seen)
    );

    function automatic int pick(inout int s, input int lo, input int hi);
        return lo + int'({$random(s)} % (hi - lo + 1));
    endfunction

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d errors so far", cycles, errors);
            $display("Something failed");
            $finish;
        end
    end

    // uart transmitter answering each start after 1 to 12 cycles
    initial begin
        tx_done = 1'b0;
        forever begin
            @(negedge clock);
            if (tx_start) begin
                repeat (pick(tx_seed, 1, 12)) @(negedge clock);
                tx_done = 1'b1;
                @(negedge clock);
                tx_done = 1'b0;
            end
        end
    end

    // all tasks start and end on a falling edge
    task automatic send_byte(input logic [7:0] b);
        repeat (pick(seed, 0, 3)) @(negedge clock); // random idle gap
        rx = '{done: 1'b1, data: b};
        @(negedge clock);
        rx.done = 1'b0;
    endtask

    task automatic tell_checker(input logic [7:0] cmd, input im_write_t wr);
        note     = 1'b1;
        note_cmd = cmd;
        note_wr  = wr;
        @(negedge clock);
        note     = 1'b0;
    endtask

    task automatic load_program(input int size);
        logic [7:0] b;
        send_byte(`DBG_CMD_LOAD);
        send_byte(8'(size));       // size lsb first
        send_byte(8'(size >> 8));
        for (int i = 0; i < size; i++) begin
            b = 8'(pick(seed, 0, 255));
            tell_checker(`DBG_CMD_LOAD, '{addr: 16'(i), data: b});
            send_byte(b);
        end
        repeat (3) @(negedge clock);
    endtask

    task automatic run_cpu();
        tell_checker(`DBG_CMD_RUN, '0);
        send_byte(`DBG_CMD_RUN);
        repeat (pick(seed, 3, 40)) @(negedge clock);
        hlt = 1'b1; // processor halts
        @(negedge clock);
        hlt = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    task automatic step_cpu();
        tell_checker(`DBG_CMD_STEP, '0);
        send_byte(`DBG_CMD_STEP);
        repeat (4) @(negedge clock);
    endtask

    task automatic dump_state(input logic [7:0] cmd, input logic with_noise);
        int target;
        target = dumps_seen + 1;
        tell_checker(cmd, '0);
        send_byte(cmd);
        if (with_noise) begin
            // all of these land while the dump is still being produced
            send_byte(`DBG_CMD_STEP);
            send_byte(`DBG_CMD_SEND_PC);
            send_byte(`DBG_CMD_LOAD);
        end
        while (dumps_seen < target) @(negedge clock);
    endtask

    initial begin
        reset    = 1'b1;
        rx       = '{done: 1'b0, data: 8'h00};
        hlt      = 1'b0;
        note     = 1'b0;
        note_cmd = 8'h00;
        note_wr  = '0;
        for (int i = 0; i < `DBG_BR_COUNT; i++)
            br_model[i] = $random(seed);
        for (int i = 0; i < `DBG_DM_DEPTH; i++)
            dm_model[i] = 8'($random(seed));
        pc_model = $random(seed);
        repeat (5) @(negedge clock);
        reset = 1'b0;

        load_program(20);
        load_program(0);   // must write nothing
        step_cpu();
        run_cpu();
        step_cpu();
        dump_state(`DBG_CMD_SEND_BR, 1'b1);
        dump_state(`DBG_CMD_SEND_MEM, 1'b1);
        dump_state(`DBG_CMD_SEND_PC, 1'b0);
        repeat (10) @(negedge clock);

        total_errors = errors + tb_checker_inst.end_checks();
        $display("checks %0d, errors %0d", checks, total_errors);
        if (total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
debug_pkg.sv
debug_unit.sv
tx_fifo.sv
tx_sender.sv
debug_top.sv
tb_checker.sv
tb_debug_top.sv

// ==== Makefile ====
# Verilator flow for the debug unit testbench
VERILATOR ?= verilator
TOP       ?= tb_debug_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Everything OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass message shows up as its own line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
